/* include/decoder_cfg.svh */
`ifndef DECODER_CFG_SVH
`define DECODER_CFG_SVH

`define OP_W            6
`define FUNCT_W         6
`define REG_ADDR_W      5
`define IMM_W           16
`define TARGET_W        26
`define ALU_OP_W        8
`define BRANCH_TYPE_W   4

`define LINK_REG        5'd31   // ra, target of the linking jumps

// opcodes
`define OP_SPECIAL      6'b000000
`define OP_REGIMM       6'b000001
`define OP_J            6'b000010
`define OP_JAL          6'b000011
`define OP_BEQ          6'b000100
`define OP_BNE          6'b000101
`define OP_BLEZ         6'b000110
`define OP_BGTZ         6'b000111
`define OP_ADDI         6'b001000
`define OP_ADDIU        6'b001001
`define OP_SLTI         6'b001010
`define OP_SLTIU        6'b001011
`define OP_ANDI         6'b001100
`define OP_ORI          6'b001101
`define OP_XORI         6'b001110
`define OP_LUI          6'b001111
`define OP_COP0         6'b010000
`define OP_SPECIAL2     6'b011100
`define OP_LB           6'b100000
`define OP_LH           6'b100001
`define OP_LW           6'b100011
`define OP_LBU          6'b100100
`define OP_LHU          6'b100101
`define OP_SB           6'b101000
`define OP_SH           6'b101001
`define OP_SW           6'b101011

// SPECIAL function codes
`define FUN_SLL         6'b000000
`define FUN_SRL         6'b000010
`define FUN_SRA         6'b000011
`define FUN_SLLV        6'b000100
`define FUN_SRLV        6'b000110
`define FUN_SRAV        6'b000111
`define FUN_JR          6'b001000
`define FUN_JALR        6'b001001
`define FUN_SYSCALL     6'b001100
`define FUN_BREAK       6'b001101
`define FUN_MFHI        6'b010000
`define FUN_MTHI        6'b010001
`define FUN_MFLO        6'b010010
`define FUN_MTLO        6'b010011
`define FUN_MULT        6'b011000
`define FUN_MULTU       6'b011001
`define FUN_DIV         6'b011010
`define FUN_DIVU        6'b011011
`define FUN_ADD         6'b100000
`define FUN_ADDU        6'b100001
`define FUN_SUB         6'b100010
`define FUN_SUBU        6'b100011
`define FUN_AND         6'b100100
`define FUN_OR          6'b100101
`define FUN_XOR         6'b100110
`define FUN_NOR         6'b100111
`define FUN_SLT         6'b101010
`define FUN_SLTU        6'b101011

// funct[5:2] groups
`define FUNGRP_HILO     4'b0100
`define FUNGRP_MULDIV   4'b0110

// REGIMM rt codes
`define RT_BLTZ         5'b00000
`define RT_BGEZ         5'b00001
`define RT_BLTZAL       5'b10000
`define RT_BGEZAL       5'b10001

`define ALUOP_NOP       8'h00
`define ALUOP_AND       8'h01
`define ALUOP_OR        8'h02
`define ALUOP_XOR       8'h03
`define ALUOP_NOR       8'h04
`define ALUOP_SLT       8'h05
`define ALUOP_SLTU      8'h06
`define ALUOP_ADD       8'h07
`define ALUOP_ADDU      8'h08
`define ALUOP_SUB       8'h09
`define ALUOP_SUBU      8'h0a
`define ALUOP_MULT      8'h0b
`define ALUOP_MULTU     8'h0c
`define ALUOP_DIV       8'h0d
`define ALUOP_DIVU      8'h0e
`define ALUOP_SLL       8'h0f
`define ALUOP_SLLV      8'h10
`define ALUOP_SRL       8'h11
`define ALUOP_SRLV      8'h12
`define ALUOP_SRA       8'h13
`define ALUOP_SRAV      8'h14
`define ALUOP_MFHI      8'h15
`define ALUOP_MFLO      8'h16
`define ALUOP_MTHI      8'h17
`define ALUOP_MTLO      8'h18
`define ALUOP_LUI       8'h19

`define BT_NOP          4'd0
`define BT_JREG         4'd1
`define BT_J            4'd2
`define BT_BEQ          4'd3
`define BT_BNE          4'd4
`define BT_BGTZ         4'd5
`define BT_BLEZ         4'd6
`define BT_BGEZ         4'd7
`define BT_BLTZ         4'd8

`endif

/* source/decoder_pkg.sv */
`include "decoder_cfg.svh"

package decoder_pkg;

    typedef logic [`ALU_OP_W-1:0]      aluOp_t;
    typedef logic [`BRANCH_TYPE_W-1:0] branchType_t;
    typedef logic [`REG_ADDR_W-1:0]    regAddr_t;

    typedef struct packed {
        logic [`OP_W-1:0]    op;
        regAddr_t            rs;
        regAddr_t            rt;
        regAddr_t            rd;
        logic [`REG_ADDR_W-1:0] shamt;
        logic [`FUNCT_W-1:0] funct;
    } rFormat_t;

    typedef struct packed {
        logic [`OP_W-1:0]  op;
        regAddr_t          rs;
        regAddr_t          rt;
        logic [`IMM_W-1:0] imm;
    } iFormat_t;

    typedef struct packed {
        logic [`OP_W-1:0]     op;
        logic [`TARGET_W-1:0] target;
    } jFormat_t;

    // one word, read through whichever format the opcode implies
    typedef union packed {
        rFormat_t rFmt;
        iFormat_t iFmt;
        jFormat_t jFmt;
    } instrWord_u;

    typedef struct packed {
        aluOp_t aluOp;
        logic   aluSelA;      // shamt as operand A
        logic   aluSelB;      // immediate as operand B
        logic   regWen;
        logic   memEn;
        logic   memRead;
        logic   memWrite;
        logic   memToReg;
        logic   hiloWrite;
        logic   hiloAccessed;
    } ctrlSignals_t;

    typedef struct packed {
        logic undefinedInst;
        logic syscallInst;
        logic breakInst;
    } excFlags_t;

    typedef struct packed {
        branchType_t branchType;
        logic        linkPc8;
    } branchInfo_t;

    typedef struct packed {
        regAddr_t     rs;
        regAddr_t     rt;
        regAddr_t     regWaddr;
        logic [31:0]  immValue;
        ctrlSignals_t ctrl;
        branchInfo_t  branch;
        excFlags_t    exc;
    } decodedInstr_t;

    localparam ctrlSignals_t  CTRL_NOP    = '0;
    localparam decodedInstr_t DECODED_NOP = '0;

endpackage

/* source/ctrlDecode.sv */
`include "decoder_cfg.svh"

module ctrlDecode import decoder_pkg::*; (
    input  instrWord_u   instr,
    output ctrlSignals_t ctrl,
    output excFlags_t    exc
);

    logic [`FUNCT_W-1:0] funct;

    assign funct = instr.rFmt.funct;

    always_comb begin
        ctrl = CTRL_NOP;
        exc  = '0;
        case (instr.rFmt.op)
            `OP_SPECIAL: begin
                ctrl.regWen = 1'b1;
                case (funct)
                    `FUN_AND:   ctrl.aluOp = `ALUOP_AND;
                    `FUN_OR:    ctrl.aluOp = `ALUOP_OR;
                    `FUN_XOR:   ctrl.aluOp = `ALUOP_XOR;
                    `FUN_NOR:   ctrl.aluOp = `ALUOP_NOR;
                    `FUN_SLT:   ctrl.aluOp = `ALUOP_SLT;
                    `FUN_SLTU:  ctrl.aluOp = `ALUOP_SLTU;
                    `FUN_ADD:   ctrl.aluOp = `ALUOP_ADD;
                    `FUN_ADDU:  ctrl.aluOp = `ALUOP_ADDU;
                    `FUN_SUB:   ctrl.aluOp = `ALUOP_SUB;
                    `FUN_SUBU:  ctrl.aluOp = `ALUOP_SUBU;
                    `FUN_SLLV:  ctrl.aluOp = `ALUOP_SLLV;
                    `FUN_SRLV:  ctrl.aluOp = `ALUOP_SRLV;
                    `FUN_SRAV:  ctrl.aluOp = `ALUOP_SRAV;
                    `FUN_SLL: begin
                        ctrl.aluOp   = `ALUOP_SLL;
                        ctrl.aluSelA = 1'b1;
                    end
                    `FUN_SRL: begin
                        ctrl.aluOp   = `ALUOP_SRL;
                        ctrl.aluSelA = 1'b1;
                    end
                    `FUN_SRA: begin
                        ctrl.aluOp   = `ALUOP_SRA;
                        ctrl.aluSelA = 1'b1;
                    end
                    // hilo side effects added below the case
                    `FUN_MULT:  ctrl.aluOp = `ALUOP_MULT;
                    `FUN_MULTU: ctrl.aluOp = `ALUOP_MULTU;
                    `FUN_DIV:   ctrl.aluOp = `ALUOP_DIV;
                    `FUN_DIVU:  ctrl.aluOp = `ALUOP_DIVU;
                    `FUN_MFHI:  ctrl.aluOp = `ALUOP_MFHI;
                    `FUN_MFLO:  ctrl.aluOp = `ALUOP_MFLO;
                    `FUN_MTHI: begin
                        ctrl.aluOp     = `ALUOP_MTHI;
                        ctrl.hiloWrite = 1'b1;
                    end
                    `FUN_MTLO: begin
                        ctrl.aluOp     = `ALUOP_MTLO;
                        ctrl.hiloWrite = 1'b1;
                    end
                    `FUN_JR:    ctrl.regWen = 1'b0;
                    `FUN_JALR:  ctrl.aluOp = `ALUOP_NOP;   // rd <= pc+8 via link path
                    `FUN_SYSCALL: begin
                        ctrl.regWen     = 1'b0;
                        exc.syscallInst = 1'b1;
                    end
                    `FUN_BREAK: begin
                        ctrl.regWen   = 1'b0;
                        exc.breakInst = 1'b1;
                    end
                    default: begin
                        ctrl              = CTRL_NOP;
                        exc.undefinedInst = 1'b1;
                    end
                endcase
                // mult/div results only land in hi/lo
                if (funct[5:2] == `FUNGRP_MULDIV) begin
                    ctrl.regWen       = 1'b0;
                    ctrl.hiloWrite    = 1'b1;
                    ctrl.hiloAccessed = 1'b1;
                end
                if (funct[5:2] == `FUNGRP_HILO) begin
                    ctrl.hiloAccessed = 1'b1;
                end
            end
            `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU: begin
                ctrl.aluOp    = `ALUOP_ADDU;   // base + offset
                ctrl.memEn    = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWen   = 1'b1;
                ctrl.aluSelB  = 1'b1;
            end
            `OP_SB, `OP_SH, `OP_SW: begin
                ctrl.aluOp    = `ALUOP_ADDU;
                ctrl.memEn    = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluSelB  = 1'b1;
            end
            `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
            `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
                ctrl.regWen  = 1'b1;
                ctrl.aluSelB = 1'b1;
                case (instr.iFmt.op)
                    `OP_ADDI:  ctrl.aluOp = `ALUOP_ADD;
                    `OP_ADDIU: ctrl.aluOp = `ALUOP_ADDU;
                    `OP_SLTI:  ctrl.aluOp = `ALUOP_SLT;
                    `OP_SLTIU: ctrl.aluOp = `ALUOP_SLTU;
                    `OP_ANDI:  ctrl.aluOp = `ALUOP_AND;
                    `OP_ORI:   ctrl.aluOp = `ALUOP_OR;
                    `OP_XORI:  ctrl.aluOp = `ALUOP_XOR;
                    default:   ctrl.aluOp = `ALUOP_LUI;
                endcase
            end
            `OP_JAL:    ctrl.regWen = 1'b1;
            `OP_J, `OP_BEQ, `OP_BNE, `OP_BGTZ, `OP_BLEZ: begin
                ctrl.aluOp = `ALUOP_NOP;   // resolved in the branch unit
            end
            `OP_REGIMM: begin
                if (instr.iFmt.rt == `RT_BGEZAL || instr.iFmt.rt == `RT_BLTZAL) begin
                    ctrl.regWen = 1'b1;
                end
            end
            // cop0, special2 and anything unassigned
            default:    exc.undefinedInst = 1'b1;
        endcase
    end

endmodule

/* source/branchDecode.sv */
`include "decoder_cfg.svh"

module branchDecode import decoder_pkg::*; (
    input  instrWord_u  instr,
    output branchInfo_t branch
);

    always_comb begin
        branch.branchType = `BT_NOP;
        branch.linkPc8    = 1'b0;
        case (instr.jFmt.op)
            `OP_SPECIAL: begin
                case (instr.rFmt.funct)
                    `FUN_JR: branch.branchType = `BT_JREG;
                    `FUN_JALR: begin
                        branch.branchType = `BT_JREG;
                        branch.linkPc8    = 1'b1;
                    end
                    default: branch.branchType = `BT_NOP;
                endcase
            end
            `OP_J:      branch.branchType = `BT_J;
            `OP_JAL: begin
                branch.branchType = `BT_J;
                branch.linkPc8    = 1'b1;   // ra <= pc+8
            end
            `OP_BEQ:    branch.branchType = `BT_BEQ;
            `OP_BNE:    branch.branchType = `BT_BNE;
            `OP_BGTZ:   branch.branchType = `BT_BGTZ;
            `OP_BLEZ:   branch.branchType = `BT_BLEZ;
            `OP_REGIMM: begin
                // condition is picked by rt here
                case (instr.iFmt.rt)
                    `RT_BGEZ: branch.branchType = `BT_BGEZ;
                    `RT_BLTZ: branch.branchType = `BT_BLTZ;
                    `RT_BGEZAL: begin
                        branch.branchType = `BT_BGEZ;
                        branch.linkPc8    = 1'b1;
                    end
                    `RT_BLTZAL: begin
                        branch.branchType = `BT_BLTZ;
                        branch.linkPc8    = 1'b1;
                    end
                    default: branch.branchType = `BT_NOP;
                endcase
            end
            default:    branch.branchType = `BT_NOP;
        endcase
    end

endmodule

/* source/operandDecode.sv */
`include "decoder_cfg.svh"

module operandDecode import decoder_pkg::*; (
    input  instrWord_u  instr,
    output regAddr_t    regWaddr,
    output logic [31:0] immValue
);

    logic zeroExt;

    // andi/ori/xori/lui share op[3:2] == 2'b11
    assign zeroExt  = (instr.iFmt.op[3:2] == 2'b11);
    assign immValue = zeroExt ? {16'h0000, instr.iFmt.imm}
                              : {{16{instr.iFmt.imm[15]}}, instr.iFmt.imm};

    always_comb begin
        case (instr.iFmt.op)
            // loads
            `OP_LB,
            `OP_LH,
            `OP_LW,
            `OP_LBU,
            `OP_LHU:    regWaddr = instr.iFmt.rt;
            // immediate arith and logic
            `OP_ADDI,
            `OP_ADDIU,
            `OP_SLTI,
            `OP_SLTIU,
            `OP_ANDI,
            `OP_ORI,
            `OP_XORI,
            `OP_LUI:    regWaddr = instr.iFmt.rt;
            `OP_JAL:    regWaddr = `LINK_REG;
            `OP_REGIMM: begin
                if (instr.iFmt.rt == `RT_BGEZAL || instr.iFmt.rt == `RT_BLTZAL) begin
                    regWaddr = `LINK_REG;
                end else begin
                    regWaddr = instr.rFmt.rd;
                end
            end
            default:    regWaddr = instr.rFmt.rd;   // R-type incl. jalr
        endcase
    end

endmodule

/* source/decodeStage.sv */
module decodeStage import decoder_pkg::*; (
    input  logic          clk,
    input  logic          rstN,
    input  logic          stall,
    input  logic          inValid,
    input  instrWord_u    instr,
    output logic          outValid,
    output decodedInstr_t decoded
);

    ctrlSignals_t  ctrl;
    excFlags_t     exc;
    branchInfo_t   branch;
    regAddr_t      regWaddr;
    logic [31:0]   immValue;
    decodedInstr_t nextDecoded;

    ctrlDecode ctrlDec (
        .instr (instr),
        .ctrl  (ctrl),
        .exc   (exc)
    );

    branchDecode branchDec (
        .instr  (instr),
        .branch (branch)
    );

    operandDecode operandDec (
        .instr    (instr),
        .regWaddr (regWaddr),
        .immValue (immValue)
    );

    always_comb begin
        nextDecoded.rs       = instr.rFmt.rs;
        nextDecoded.rt       = instr.rFmt.rt;
        nextDecoded.regWaddr = regWaddr;
        nextDecoded.immValue = immValue;
        nextDecoded.ctrl     = ctrl;
        nextDecoded.branch   = branch;
        nextDecoded.exc      = exc;
    end

    // single-entry stage, stall freezes both valid and payload
    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
            decoded  <= DECODED_NOP;
        end else if (!stall) begin
            outValid <= inValid;
            decoded  <= nextDecoded;   // loaded even when not valid
        end
    end

endmodule

/* verification/decodeStage_sva.sv */
module decodeStage_sva import decoder_pkg::*; (
    input logic          clk,
    input logic          rstN,
    input logic          stall,
    input logic          outValid,
    input decodedInstr_t decoded
);

    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0;   // read by the testbench summary

    resetEmpties: assert property (@(posedge clk) !rstN |=> !outValid)
        else begin
            failCount++;
            $error("outValid set on the cycle after reset");
        end

    // reset has priority, so only a stall with rstN high must hold
    stallHolds: assert property (@(posedge clk)
        (rstN && stall) |=> ($stable(decoded) && $stable(outValid)))
        else begin
            failCount++;
            $error("stage output changed across a stalled edge");
        end

    memExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(decoded.ctrl.memRead && decoded.ctrl.memWrite))
        else begin
            failCount++;
            $error("memRead and memWrite both set");
        end

endmodule

bind decodeStage decodeStage_sva decodeChecks (
    .clk      (clk),
    .rstN     (rstN),
    .stall    (stall),
    .outValid (outValid),
    .decoded  (decoded)
);

/* verification/decodeStage_tb.sv */
`include "decoder_cfg.svh"

module decodeStage_tb import decoder_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic          clk;
    logic          rstN;
    logic          stall;
    logic          inValid;
    instrWord_u    instr;
    logic          outValid;
    decodedInstr_t decoded;

    integer seed;
    int     errorCount = 0;
    int     checkCount = 0;
    int     issued = 0;

    decodeStage UUT (
        .clk      (clk),
        .rstN     (rstN),
        .stall    (stall),
        .inValid  (inValid),
        .instr    (instr),
        .outValid (outValid),
        .decoded  (decoded)
    );

    always #10 clk = ~clk;

    task automatic tally(input logic ok, input string msg);
        checkCount++;
        if (!ok) begin
            errorCount++;
            $display("FAILED at %0t ns: %s", $time, msg);
        end
    endtask

    task automatic checkCtrl(input string name, input ctrlSignals_t got, input ctrlSignals_t exp);
        tally(got === exp, $sformatf("%s ctrl got %h, expected %h", name, got, exp));
    endtask
    task automatic checkExc(input string name, input excFlags_t got, input excFlags_t exp);
        tally(got === exp, $sformatf("%s exc got %b, expected %b", name, got, exp));
    endtask
    task automatic checkBranch(input string name, input branchInfo_t got, input branchInfo_t exp);
        tally(got === exp, $sformatf("%s branch got %h, expected %h", name, got, exp));
    endtask
    task automatic checkReg(input string name, input string field, input regAddr_t got,
                            input regAddr_t exp);
        tally(got === exp, $sformatf("%s %s got %0d, expected %0d", name, field, got, exp));
    endtask
    task automatic checkWaddr(input string name, input regAddr_t got, input regAddr_t exp);
        checkReg(name, "regWaddr", got, exp);
    endtask
    task automatic checkImm(input string name, input logic [31:0] got, input logic [31:0] exp);
        tally(got === exp, $sformatf("%s immValue got %h, expected %h", name, got, exp));
    endtask
    task automatic checkValid(input string name, input logic got, input logic exp);
        tally(got === exp, $sformatf("%s outValid got %b, expected %b", name, got, exp));
    endtask

    function automatic regAddr_t randReg();
        integer r;
        r = $random(seed);
        return r[4:0];
    endfunction

    function automatic logic [15:0] randImm();
        integer r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic instrWord_u makeR(regAddr_t rs, regAddr_t rt, regAddr_t rd,
                                         regAddr_t shamt, logic [5:0] funct);
        instrWord_u w;
        w = {`OP_SPECIAL, rs, rt, rd, shamt, funct};
        return w;
    endfunction

    function automatic instrWord_u makeI(logic [5:0] op, regAddr_t rs, regAddr_t rt,
                                         logic [15:0] imm);
        instrWord_u w;
        w = {op, rs, rt, imm};
        return w;
    endfunction

    // op[3:2] == 11 zero-extends, all else sign-extends
    function automatic logic [31:0] extImm(instrWord_u w);
        if (w.iFmt.op[3] && w.iFmt.op[2]) begin
            return {16'h0000, w.iFmt.imm};
        end
        return {{16{w.iFmt.imm[15]}}, w.iFmt.imm};
    endfunction

    // called on a falling edge, returns on the next one
    task automatic issue(input instrWord_u w, input logic valid, input logic hold);
        instr   = w;
        inValid = valid;
        stall   = hold;
        issued++;
        @(negedge clk);
    endtask

    task automatic runCase(input string name, input instrWord_u w, input ctrlSignals_t expCtrl,
                           input excFlags_t expExc, input branchInfo_t expBr,
                           input regAddr_t expWaddr, input logic [31:0] expImm);
        issue(w, 1'b1, 1'b0);
        checkValid(name, outValid, 1'b1);
        checkReg(name, "rs", decoded.rs, w.rFmt.rs);
        checkReg(name, "rt", decoded.rt, w.rFmt.rt);
        checkCtrl(name, decoded.ctrl, expCtrl);
        checkExc(name, decoded.exc, expExc);
        checkBranch(name, decoded.branch, expBr);
        checkWaddr(name, decoded.regWaddr, expWaddr);
        checkImm(name, decoded.immValue, expImm);
    endtask

    task automatic checkCleared(input string name);
        checkValid(name, outValid, 1'b0);
        checkReg(name, "rs", decoded.rs, '0);
        checkReg(name, "rt", decoded.rt, '0);
        checkCtrl(name, decoded.ctrl, CTRL_NOP);
        checkExc(name, decoded.exc, '0);
        checkBranch(name, decoded.branch, '0);
        checkWaddr(name, decoded.regWaddr, '0);
        checkImm(name, decoded.immValue, '0);
    endtask

    task automatic rtypeOne(input string name, input logic [5:0] funct, input aluOp_t op,
                            input logic shift);
        instrWord_u   w;
        ctrlSignals_t c;
        w = makeR(randReg(), randReg(), randReg(), randReg(), funct);
        c = CTRL_NOP;
        c.aluOp   = op;
        c.regWen  = 1'b1;
        c.aluSelA = shift;   // shamt operand
        runCase(name, w, c, '0, '0, w.rFmt.rd, extImm(w));
    endtask

    task automatic aluRtypes();
        rtypeOne("ADD", `FUN_ADD, `ALUOP_ADD, 1'b0);
        rtypeOne("ADDU", `FUN_ADDU, `ALUOP_ADDU, 1'b0);
        rtypeOne("SUB", `FUN_SUB, `ALUOP_SUB, 1'b0);
        rtypeOne("SUBU", `FUN_SUBU, `ALUOP_SUBU, 1'b0);
        rtypeOne("AND", `FUN_AND, `ALUOP_AND, 1'b0);
        rtypeOne("OR", `FUN_OR, `ALUOP_OR, 1'b0);
        rtypeOne("XOR", `FUN_XOR, `ALUOP_XOR, 1'b0);
        rtypeOne("NOR", `FUN_NOR, `ALUOP_NOR, 1'b0);
        rtypeOne("SLT", `FUN_SLT, `ALUOP_SLT, 1'b0);
        rtypeOne("SLTU", `FUN_SLTU, `ALUOP_SLTU, 1'b0);
        rtypeOne("SLLV", `FUN_SLLV, `ALUOP_SLLV, 1'b0);
        rtypeOne("SRLV", `FUN_SRLV, `ALUOP_SRLV, 1'b0);
        rtypeOne("SRAV", `FUN_SRAV, `ALUOP_SRAV, 1'b0);
        rtypeOne("SLL", `FUN_SLL, `ALUOP_SLL, 1'b1);
        rtypeOne("SRL", `FUN_SRL, `ALUOP_SRL, 1'b1);
        rtypeOne("SRA", `FUN_SRA, `ALUOP_SRA, 1'b1);
    endtask

    task automatic immOne(input string name, input logic [5:0] op, input aluOp_t aluOp,
                          input logic zext, input logic [15:0] imm);
        instrWord_u   w;
        ctrlSignals_t c;
        w = makeI(op, randReg(), randReg(), imm);
        c = CTRL_NOP;
        c.aluOp   = aluOp;
        c.regWen  = 1'b1;
        c.aluSelB = 1'b1;
        runCase(name, w, c, '0, '0, w.iFmt.rt,
                zext ? {16'h0000, imm} : {{16{imm[15]}}, imm});
    endtask

    task automatic memOne(input string name, input logic [5:0] op, input logic isLoad);
        instrWord_u   w;
        ctrlSignals_t c;
        w = makeI(op, randReg(), randReg(), randImm());
        c = CTRL_NOP;
        c.aluOp    = `ALUOP_ADDU;
        c.aluSelB  = 1'b1;
        c.memEn    = 1'b1;
        c.memRead  = isLoad;
        c.memToReg = isLoad;
        c.regWen   = isLoad;
        c.memWrite = !isLoad;
        runCase(name, w, c, '0, '0, isLoad ? w.iFmt.rt : w.rFmt.rd, extImm(w));
    endtask

    task automatic branchOne(input string name, input instrWord_u w, input branchType_t bt,
                             input logic link, input regAddr_t waddr);
        ctrlSignals_t c;
        branchInfo_t  b;
        c = CTRL_NOP;
        c.regWen     = link;   // linking forms write pc+8
        b.branchType = bt;
        b.linkPc8    = link;
        runCase(name, w, c, '0, b, waddr, extImm(w));
    endtask

    task automatic branchOps();
        instrWord_u w;
        w = makeR(randReg(), randReg(), randReg(), randReg(), `FUN_JR);
        branchOne("JR", w, `BT_JREG, 1'b0, w.rFmt.rd);
        w = makeR(randReg(), randReg(), randReg(), randReg(), `FUN_JALR);
        branchOne("JALR", w, `BT_JREG, 1'b1, w.rFmt.rd);
        w = makeI(`OP_J, randReg(), randReg(), randImm());
        branchOne("J", w, `BT_J, 1'b0, w.rFmt.rd);
        w = makeI(`OP_JAL, randReg(), randReg(), randImm());
        branchOne("JAL", w, `BT_J, 1'b1, `LINK_REG);
        w = makeI(`OP_BEQ, randReg(), randReg(), 16'hfffc);
        branchOne("BEQ", w, `BT_BEQ, 1'b0, w.rFmt.rd);
        w = makeI(`OP_BNE, randReg(), randReg(), randImm());
        branchOne("BNE", w, `BT_BNE, 1'b0, w.rFmt.rd);
        w = makeI(`OP_BGTZ, randReg(), 5'd0, randImm());
        branchOne("BGTZ", w, `BT_BGTZ, 1'b0, w.rFmt.rd);
        w = makeI(`OP_BLEZ, randReg(), 5'd0, randImm());
        branchOne("BLEZ", w, `BT_BLEZ, 1'b0, w.rFmt.rd);
        w = makeI(`OP_REGIMM, randReg(), `RT_BGEZ, randImm());
        branchOne("BGEZ", w, `BT_BGEZ, 1'b0, w.rFmt.rd);
        w = makeI(`OP_REGIMM, randReg(), `RT_BLTZ, randImm());
        branchOne("BLTZ", w, `BT_BLTZ, 1'b0, w.rFmt.rd);
        w = makeI(`OP_REGIMM, randReg(), `RT_BGEZAL, randImm());
        branchOne("BGEZAL", w, `BT_BGEZ, 1'b1, `LINK_REG);
        w = makeI(`OP_REGIMM, randReg(), `RT_BLTZAL, randImm());
        branchOne("BLTZAL", w, `BT_BLTZ, 1'b1, `LINK_REG);
    endtask

    task automatic hiloOne(input string name, input logic [5:0] funct, input aluOp_t op,
                           input logic wen, input logic hiloWr);
        instrWord_u   w;
        ctrlSignals_t c;
        w = makeR(randReg(), randReg(), randReg(), 5'd0, funct);
        c = CTRL_NOP;
        c.aluOp        = op;
        c.regWen       = wen;
        c.hiloWrite    = hiloWr;
        c.hiloAccessed = 1'b1;
        runCase(name, w, c, '0, '0, w.rFmt.rd, extImm(w));
    endtask

    task automatic exceptionOne(input string name, input instrWord_u w, input excFlags_t e);
        runCase(name, w, CTRL_NOP, e, '0, w.rFmt.rd, extImm(w));
    endtask

    task automatic pipelineControl();
        instrWord_u   first;
        instrWord_u   second;
        ctrlSignals_t c;
        first  = makeR(randReg(), randReg(), randReg(), 5'd0, `FUN_ADDU);
        second = makeI(`OP_LW, randReg(), randReg(), 16'h8010);
        c = CTRL_NOP;
        c.aluOp  = `ALUOP_ADDU;
        c.regWen = 1'b1;
        issue(first, 1'b1, 1'b0);
        checkCtrl("before stall", decoded.ctrl, c);
        issue(second, 1'b1, 1'b1);   // LW waits at the input
        checkValid("stalled", outValid, 1'b1);
        checkCtrl("stalled", decoded.ctrl, c);
        checkWaddr("stalled", decoded.regWaddr, first.rFmt.rd);
        issue(second, 1'b1, 1'b0);
        checkWaddr("after stall", decoded.regWaddr, second.iFmt.rt);
        checkImm("after stall", decoded.immValue, 32'hffff8010);
        issue(first, 1'b0, 1'b0);
        checkValid("bubble", outValid, 1'b0);
        // reset beats stall
        issue(first, 1'b1, 1'b0);
        rstN = 1'b0;
        issue(second, 1'b1, 1'b1);
        rstN = 1'b1;
        checkCleared("reset during stall");
    endtask

    initial begin
        seed    = 32'h8459c1d7;
        clk     = 1'b0;
        rstN    = 1'b0;
        stall   = 1'b0;
        inValid = 1'b0;
        instr   = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        checkCleared("after reset");
        aluRtypes();
        immOne("ADDI neg", `OP_ADDI, `ALUOP_ADD, 1'b0, 16'hfff0);
        immOne("ADDI", `OP_ADDI, `ALUOP_ADD, 1'b0, randImm());
        immOne("SLTI", `OP_SLTI, `ALUOP_SLT, 1'b0, 16'h8000);
        immOne("ANDI", `OP_ANDI, `ALUOP_AND, 1'b1, 16'h8001);
        immOne("ORI", `OP_ORI, `ALUOP_OR, 1'b1, 16'hffff);
        immOne("LUI", `OP_LUI, `ALUOP_LUI, 1'b1, randImm());
        memOne("LB", `OP_LB, 1'b1);
        memOne("LW", `OP_LW, 1'b1);
        memOne("LHU", `OP_LHU, 1'b1);
        memOne("SB", `OP_SB, 1'b0);
        memOne("SW", `OP_SW, 1'b0);
        branchOps();
        hiloOne("MULT", `FUN_MULT, `ALUOP_MULT, 1'b0, 1'b1);
        hiloOne("MULTU", `FUN_MULTU, `ALUOP_MULTU, 1'b0, 1'b1);
        hiloOne("DIV", `FUN_DIV, `ALUOP_DIV, 1'b0, 1'b1);
        hiloOne("DIVU", `FUN_DIVU, `ALUOP_DIVU, 1'b0, 1'b1);
        hiloOne("MFHI", `FUN_MFHI, `ALUOP_MFHI, 1'b1, 1'b0);
        hiloOne("MFLO", `FUN_MFLO, `ALUOP_MFLO, 1'b1, 1'b0);
        hiloOne("MTHI", `FUN_MTHI, `ALUOP_MTHI, 1'b1, 1'b1);
        hiloOne("MTLO", `FUN_MTLO, `ALUOP_MTLO, 1'b1, 1'b1);
        // flags are {undefined, syscall, break}
        exceptionOne("SYSCALL", makeR(randReg(), 5'd0, 5'd0, 5'd0, `FUN_SYSCALL), 3'b010);
        exceptionOne("BREAK", makeR(randReg(), 5'd0, 5'd0, 5'd0, `FUN_BREAK), 3'b001);
        exceptionOne("bad funct", makeR(randReg(), randReg(), randReg(), 5'd0, 6'b000001),
                     3'b100);
        exceptionOne("COP0", makeI(`OP_COP0, randReg(), randReg(), randImm()), 3'b100);
        exceptionOne("SPECIAL2", makeI(`OP_SPECIAL2, randReg(), randReg(), randImm()), 3'b100);
        pipelineControl();
        errorCount = errorCount + UUT.decodeChecks.failCount;
        $display("checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // budget grows with each issued instruction
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < 200 + 10 * issued) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: tests did not finish within %0d cycles", cycles);
        $display("Testbench failed");
        $finish;
    end

endmodule

/* decodeStage.f */
+incdir+include
source/decoder_pkg.sv
source/ctrlDecode.sv
source/branchDecode.sv
source/operandDecode.sv
source/decodeStage.sv
verification/decodeStage_sva.sv
verification/decodeStage_tb.sv

/* Makefile */
TOP = decodeStage_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check run.log"
	@echo "make clean  remove obj_dir and run.log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f decodeStage.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee run.log
	grep -q "Testbench passed" run.log

clean:
	rm -rf obj_dir run.log
